// ==== hw/fifo_host_defines.svh ====
// Widths and depths shared by the ring reader design, pulled in with `include where needed
`ifndef FIFO_HOST_DEFINES_SVH
`define FIFO_HOST_DEFINES_SVH

// One cache line of payload carried on the memory response bus
`define FH_DATA_W 64

// Line address width on the memory request bus
`define FH_ADDR_W 32

// The ring holds 64 lines, so the index wraps naturally at 6 bits
`define FH_RING_IDX_W 6

// Number of reads that may be in flight at once
`define FH_SB_ENTRIES 8

// Bits needed to name one scoreboard slot
`define FH_SB_IDX_W 3

// Request tag width, echoed back unchanged with the response
`define FH_MDATA_W 8

`endif

// ==== hw/fifo_host_pkg.sv ====
// Types for ring indices, addresses, line data and the read tag; imported by the RTL modules
`default_nettype none

`include "fifo_host_defines.svh"

package fifo_host_pkg;

    // Position of a line inside the host ring
    typedef logic [`FH_RING_IDX_W-1:0] t_ring_idx;

    // Cache-line granular memory address
    typedef logic [`FH_ADDR_W-1:0] t_line_addr;

    // Payload of one cache line
    typedef logic [`FH_DATA_W-1:0] t_line_data;

    // Slot number in the reorder scoreboard
    typedef logic [`FH_SB_IDX_W-1:0] t_sb_idx;

    // ======================================
    // Read tag layout
    // ======================================

    // The reader encodes the scoreboard slot in the tag so that a response
    // can be written straight into its slot whatever order it arrives in
    typedef struct packed {
        logic                                is_read;
        logic [`FH_MDATA_W-`FH_SB_IDX_W-2:0] reserved;
        t_sb_idx                             rob_idx;
    } t_read_meta;

    // The memory port sees only the raw bits of the tag
    typedef union packed {
        t_read_meta             meta;
        logic [`FH_MDATA_W-1:0] raw;
    } t_mdata;

endpackage

`default_nettype wire

// ==== hw/reorder_if.sv ====
// Bundle between the ring reader and the reorder scoreboard; the reader owns allocate, fill, drain
`timescale 1ns/10ps
`default_nettype none

interface reorder_if
    import fifo_host_pkg::*;
();

    // Allocation side, one slot per granted read
    logic       alloc_en;
    logic       alloc_rdy;
    t_sb_idx    alloc_idx;

    // Fill side, written as responses arrive in any order
    logic       fill_en;
    t_sb_idx    fill_idx;
    t_line_data fill_data;

    // Drain side, always the oldest allocated slot
    logic       drain_en;
    logic       head_valid;
    t_line_data head_data;

    // The reader issues requests, steers responses and pulls the head
    modport owner (
        output alloc_en, fill_en, fill_idx, fill_data, drain_en,
        input  alloc_rdy, alloc_idx, head_valid, head_data
    );

    // The scoreboard reports free space and the state of its head
    modport scoreboard (
        input  alloc_en, fill_en, fill_idx, fill_data, drain_en,
        output alloc_rdy, alloc_idx, head_valid, head_data
    );

endinterface

`default_nettype wire

// ==== hw/reorder_scoreboard.sv ====
// Reorder buffer for read responses; slots are allocated and drained in order, filled in any order
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module reorder_scoreboard
    import fifo_host_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         resetb,
    reorder_if.scoreboard     sb
);

    // ======================================
    // Storage and pointers
    // ======================================

    // Line storage, one entry per outstanding read
    t_line_data data_mem [`FH_SB_ENTRIES];

    // Set when the response for a slot has landed
    logic [`FH_SB_ENTRIES-1:0] filled;

    // One extra pointer bit tells a full buffer from an empty one
    logic [`FH_SB_IDX_W:0] alloc_ptr;
    logic [`FH_SB_IDX_W:0] head_ptr;

    // Number of slots currently allocated
    logic [`FH_SB_IDX_W:0] sb_count;
    logic                  sb_empty;
    t_sb_idx               head_idx;

    // Distance of a fill slot from the head, used by the checks below
    t_sb_idx               fill_offset;

    assign sb_count    = alloc_ptr - head_ptr;
    assign sb_empty    = (sb_count == '0);
    assign head_idx    = head_ptr[`FH_SB_IDX_W-1:0];
    assign fill_offset = sb.fill_idx - head_idx;

    // ======================================
    // Status toward the owner
    // ======================================

    assign sb.alloc_rdy  = (sb_count != (`FH_SB_IDX_W+1)'(`FH_SB_ENTRIES));
    assign sb.alloc_idx  = alloc_ptr[`FH_SB_IDX_W-1:0];

    // The flag is a register, so a fill shows at the head one cycle later
    assign sb.head_valid = !sb_empty && filled[head_idx];
    assign sb.head_data  = data_mem[head_idx];

    // Pointers and fill flags
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            alloc_ptr <= '0;
            head_ptr  <= '0;
            filled    <= '0;
        end
        else
        begin
            if (sb.alloc_en)
                alloc_ptr <= alloc_ptr + 1'b1;

            // Clearing on drain leaves the slot ready for its next use
            if (sb.drain_en)
            begin
                head_ptr         <= head_ptr + 1'b1;
                filled[head_idx] <= 1'b0;
            end

            if (sb.fill_en)
                filled[sb.fill_idx] <= 1'b1;
        end
    end

    // Payload write, any slot in any order
    always_ff @(posedge clk)
    begin
        if (sb.fill_en)
            data_mem[sb.fill_idx] <= sb.fill_data;
    end

    // A response must target a slot that was handed out and not yet filled
    a_fill_allocated: assert property (@(posedge clk) disable iff (!resetb)
        sb.fill_en |-> (({1'b0, fill_offset} < sb_count) && !filled[sb.fill_idx]));

    // The owner may only pull the head once its data is present
    a_drain_valid: assert property (@(posedge clk) disable iff (!resetb)
        sb.drain_en |-> sb.head_valid);

endmodule

`default_nettype wire

// ==== hw/out_fifo2.sv ====
// Two-entry buffer between the scoreboard head and the client, at one line per cycle
`timescale 1ns/10ps
`default_nettype none

module out_fifo2
    import fifo_host_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        resetb,
    input  wire logic        enq_en,
    input  wire t_line_data  enq_data,
    output logic             not_full,
    output t_line_data       first,
    input  wire logic        deq_en,
    output logic             not_empty
);

    // Entry 0 is always the oldest, entry 1 only fills behind it
    t_line_data data0;
    t_line_data data1;
    logic       valid0;
    logic       valid1;

    assign first     = data0;
    assign not_empty = valid0;
    // With one line held an enqueue and a dequeue may still happen together
    assign not_full  = !valid1;

    // Valid bits
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else
        begin
            case ({enq_en, deq_en})
                2'b10:
                begin
                    if (valid0)
                        valid1 <= 1'b1;
                    else
                        valid0 <= 1'b1;
                end
                2'b01:
                begin
                    valid0 <= valid1;
                    valid1 <= 1'b0;
                end
                default:
                begin
                    // Both or neither, so occupancy does not change
                    valid0 <= valid0;
                    valid1 <= valid1;
                end
            endcase
        end
    end

    // Payload moves forward on dequeue, new data lands in the first free place
    always_ff @(posedge clk)
    begin
        if (deq_en)
            data0 <= (enq_en && !valid1) ? enq_data : data1;
        else if (enq_en && !valid0)
            data0 <= enq_data;

        if (enq_en && (valid1 || (valid0 && !deq_en)))
            data1 <= enq_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!resetb)
        enq_en |-> not_full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!resetb)
        deq_en |-> not_empty);

endmodule

`default_nettype wire

// ==== hw/ring_csr.sv ====
// Host-written ring settings, the base line address and the index past the newest posted line
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module ring_csr
    import fifo_host_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        resetb,

    // Single write port, the selector picks the register
    input  wire logic        csr_wr_en,
    input  wire logic        csr_sel,
    input  wire t_line_addr  csr_wr_data,

    output t_line_addr       base_addr,
    output t_ring_idx        newest_idx
);

    // ======================================
    // Register map
    // ======================================

    // Selector value for each register
    localparam logic SEL_BASE   = 1'b0;
    localparam logic SEL_NEWEST = 1'b1;

    // The host advances the newest index as it writes lines into the ring;
    // the reader chases it until the two are equal.
    // Only the low ring index bits carry meaning, the rest are dropped
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            base_addr  <= '0;
            newest_idx <= '0;
        end
        else if (csr_wr_en)
        begin
            case (csr_sel)
                SEL_BASE:
                    base_addr <= csr_wr_data;
                SEL_NEWEST:
                    newest_idx <= csr_wr_data[`FH_RING_IDX_W-1:0];
                default:
                begin
                    base_addr  <= base_addr;
                    newest_idx <= newest_idx;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/ring_reader.sv ====
// Ring read engine; issues tagged line reads, feeds the scoreboard and drains it in ring order
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module ring_reader
    import fifo_host_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   resetb,

    // Settings from the register block
    input  wire t_line_addr             base_addr,
    input  wire t_ring_idx              newest_idx,

    // Memory read request, a level answered by a grant strobe
    output logic                        rd_req,
    output t_line_addr                  rd_addr,
    output logic [`FH_MDATA_W-1:0]      rd_mdata,
    input  wire logic                   rd_grant,

    // Memory read response, returned in any order
    input  wire logic                   rsp_valid,
    input  wire logic [`FH_MDATA_W-1:0] rsp_mdata,
    input  wire t_line_data             rsp_data,

    reorder_if.owner                    sb,

    // Toward the output buffer
    output logic                        enq_en,
    output t_line_data                  enq_data,
    input  wire logic                   not_full,

    output t_ring_idx                   oldest_idx
);

    // Next ring slot to request
    t_ring_idx next_idx;

    t_mdata    req_tag;
    t_mdata    rsp_tag;

    // ======================================
    // Request side
    // ======================================

    // Read while the host has posted lines we have not asked for and a
    // reorder slot is free to receive the answer
    assign rd_req = (next_idx != newest_idx) && sb.alloc_rdy;

    // Adding rather than splicing low bits lets the ring sit at any base
    assign rd_addr = base_addr + t_line_addr'(next_idx);

    // The tag carries the slot this read will fill
    always_comb
    begin
        req_tag.meta.is_read  = 1'b1;
        req_tag.meta.reserved = '0;
        req_tag.meta.rob_idx  = sb.alloc_idx;
    end
    assign rd_mdata = req_tag.raw;

    // A granted read owns the slot named in its tag
    assign sb.alloc_en = rd_grant;

    always_ff @(posedge clk)
    begin
        if (!resetb)
            next_idx <= '0;
        else if (rd_grant)
            next_idx <= next_idx + 1'b1;
    end

    // ======================================
    // Response and drain side
    // ======================================

    // Only read responses go into the scoreboard
    assign rsp_tag.raw  = rsp_mdata;
    assign sb.fill_en   = rsp_valid && rsp_tag.meta.is_read;
    assign sb.fill_idx  = rsp_tag.meta.rob_idx;
    assign sb.fill_data = rsp_data;

    // Move the head across whenever the output buffer has room
    assign enq_en      = sb.head_valid && not_full;
    assign enq_data    = sb.head_data;
    assign sb.drain_en = enq_en;

    // The host may reuse a slot once its line has left the scoreboard.
    // Counting here avoids tracking fills that arrive out of order
    always_ff @(posedge clk)
    begin
        if (!resetb)
            oldest_idx <= '0;
        else if (enq_en)
            oldest_idx <= oldest_idx + 1'b1;
    end

    // The arbiter may only grant a request that is being raised
    a_grant_with_req: assert property (@(posedge clk) disable iff (!resetb)
        rd_grant |-> rd_req);

endmodule

`default_nettype wire

// ==== hw/fifo_from_host_top.sv ====
// Top level of the host ring reader; plain ports toward memory, register writes and the client
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module fifo_from_host_top
    import fifo_host_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     resetb,

    input  wire logic                     csr_wr_en,
    input  wire logic                     csr_sel,
    input  wire logic [`FH_ADDR_W-1:0]    csr_wr_data,

    output logic                          rd_req,
    output logic [`FH_ADDR_W-1:0]         rd_addr,
    output logic [`FH_MDATA_W-1:0]        rd_mdata,
    input  wire logic                     rd_grant,

    input  wire logic                     rsp_valid,
    input  wire logic [`FH_MDATA_W-1:0]   rsp_mdata,
    input  wire logic [`FH_DATA_W-1:0]    rsp_data,

    output logic [`FH_DATA_W-1:0]         rx_data,
    output logic                          rx_rdy,
    input  wire logic                     rx_enable,

    output logic [`FH_RING_IDX_W-1:0]     oldest_idx
);

    t_line_addr base_addr;
    t_ring_idx  newest_idx;
    logic       enq_en;
    t_line_data enq_data;
    logic       not_full;
    logic       client_deq;

    // The client may hold enable high while nothing is ready
    assign client_deq = rx_enable && rx_rdy;

    reorder_if u_rob_if ();

    ring_csr u_ring_csr (
        .clk, .resetb, .csr_wr_en, .csr_sel, .csr_wr_data,
        .base_addr, .newest_idx
    );

    ring_reader u_ring_reader (
        .clk, .resetb, .base_addr, .newest_idx,
        .rd_req, .rd_addr, .rd_mdata, .rd_grant,
        .rsp_valid, .rsp_mdata, .rsp_data,
        .sb (u_rob_if.owner),
        .enq_en, .enq_data, .not_full, .oldest_idx
    );

    reorder_scoreboard u_scoreboard (.clk, .resetb, .sb (u_rob_if.scoreboard));

    out_fifo2 u_out_fifo (
        .clk, .resetb, .enq_en, .enq_data, .not_full,
        .first (rx_data), .deq_en (client_deq), .not_empty (rx_rdy)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Free-running testbench clock, instantiated once by the test top with a 100 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 50
) (
    output logic clk
);

    // Starts low, so the first rising edge comes half a period in
    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/tb_host_model.sv ====
// Host memory model for the testbench; grants reads and answers them out of order from its ring
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module tb_host_model (
    input  wire logic                     clk,
    input  wire logic                     resetb,

    // Ring contents written by the test, one line per cycle
    input  wire logic                     mem_wr_en,
    input  wire logic [`FH_RING_IDX_W-1:0] mem_wr_idx,
    input  wire logic [`FH_DATA_W-1:0]    mem_wr_data,
    input  wire logic [`FH_ADDR_W-1:0]    base,

    // Random pacing chosen by the test each cycle
    input  wire logic                     grant_try,
    input  wire logic                     ret_try,
    input  wire logic [2:0]               ret_pick,

    // Memory port of the DUT
    input  wire logic                     rd_req,
    input  wire logic [`FH_ADDR_W-1:0]    rd_addr,
    input  wire logic [`FH_MDATA_W-1:0]   rd_mdata,
    output logic                          rd_grant,
    output logic                          rsp_valid,
    output logic [`FH_MDATA_W-1:0]        rsp_mdata,
    output logic [`FH_DATA_W-1:0]         rsp_data
);

    // One ring of 64 lines as the host wrote it
    logic [`FH_DATA_W-1:0]     ring_mem [64];

    // Reads that were granted and still wait for their answer
    logic [`FH_RING_IDX_W-1:0] pend_idx [$];
    logic [`FH_MDATA_W-1:0]    pend_tag [$];

    initial
    begin
        rd_grant  = 1'b0;
        rsp_valid = 1'b0;
        rsp_mdata = '0;
        rsp_data  = '0;
    end

    // Mid-cycle sampling, where every input has settled
    always @(negedge clk)
    begin
        logic [`FH_ADDR_W-1:0] offset;
        if (mem_wr_en)
            ring_mem[mem_wr_idx] <= mem_wr_data;
        // A grant held now is taken at the coming rising edge
        if (resetb && rd_grant)
        begin
            offset = rd_addr - base;
            pend_idx.push_back(offset[`FH_RING_IDX_W-1:0]);
            pend_tag.push_back(rd_mdata);
        end
    end

    // Driven later than the test's own inputs so the pacing bits are already set
    always @(posedge clk)
    begin
        int pick;
        #2;
        rd_grant  = resetb && rd_req && grant_try;
        rsp_valid = 1'b0;
        if (resetb && ret_try && (pend_idx.size() != 0))
        begin
            // Any waiting read may answer first, which scrambles the order
            pick      = int'(ret_pick) % pend_idx.size();
            rsp_valid = 1'b1;
            rsp_mdata = pend_tag[pick];
            rsp_data  = ring_mem[pend_idx[pick]];
            pend_idx.delete(pick);
            pend_tag.delete(pick);
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_fifo_from_host.sv ====
// Test top for the host ring reader; random posting and pacing, checked against a ring model
`timescale 1ns/10ps
`default_nettype none

`include "fifo_host_defines.svh"

module tb_fifo_from_host;

    localparam int          TOTAL_LINES = 500;
    localparam int          RING_LINES  = 64;
    localparam int          MAX_CYCLES  = 40000;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic                      clk;
    logic                      resetb;
    logic                      csr_wr_en;
    logic                      csr_sel;
    logic [`FH_ADDR_W-1:0]     csr_wr_data;
    logic                      rd_req;
    logic [`FH_ADDR_W-1:0]     rd_addr;
    logic [`FH_MDATA_W-1:0]    rd_mdata;
    logic                      rd_grant;
    logic                      rsp_valid;
    logic [`FH_MDATA_W-1:0]    rsp_mdata;
    logic [`FH_DATA_W-1:0]     rsp_data;
    logic [`FH_DATA_W-1:0]     rx_data;
    logic                      rx_rdy;
    logic                      rx_enable;
    logic [`FH_RING_IDX_W-1:0] oldest_idx;

    // Host side controls
    logic                      mem_wr_en;
    logic [`FH_RING_IDX_W-1:0] mem_wr_idx;
    logic [`FH_DATA_W-1:0]     mem_wr_data;
    logic [`FH_ADDR_W-1:0]     base_model;
    logic                      grant_try;
    logic                      ret_try;
    logic [2:0]                ret_pick;

    // ========================================
    // Reference model state
    // ========================================

    logic [31:0]           lfsr_state   = 32'd99;
    logic [`FH_DATA_W-1:0] ring_model [RING_LINES];
    int                    posted       = 0;
    int                    posted_seen  = 0;
    int                    req_count    = 0;
    int                    rsp_count    = 0;
    int                    rx_count     = 0;
    int                    batch_left   = 0;
    int                    fill_pos     = 0;
    int                    hold_left    = 0;
    logic                  post_pending = 1'b0;
    logic                  base_moved   = 1'b0;
    logic                  run_en       = 1'b0;
    logic                  held_prev    = 1'b0;
    logic [`FH_DATA_W-1:0] held_data    = '0;

    tb_clock u_clock (.clk);

    tb_host_model u_host_model (
        .clk, .resetb, .mem_wr_en, .mem_wr_idx, .mem_wr_data, .base (base_model),
        .grant_try, .ret_try, .ret_pick,
        .rd_req, .rd_addr, .rd_mdata, .rd_grant, .rsp_valid, .rsp_mdata, .rsp_data
    );

    fifo_from_host_top u_fifo_from_host_top (
        .clk, .resetb, .csr_wr_en, .csr_sel, .csr_wr_data,
        .rd_req, .rd_addr, .rd_mdata, .rd_grant, .rsp_valid, .rsp_mdata, .rsp_data,
        .rx_data, .rx_rdy, .rx_enable, .oldest_idx
    );

    // Galois LFSR, one step per bit handed out
    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb)
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            value = {value[62:0], lsb};
        end
        return value;
    endfunction

    task automatic flag_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] expected);
        $display("ERR time=%0t %s got=%0h expected=%0h", $time, sig, got, expected);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // ========================================
    // Stimulus, one draw sequence per cycle
    // ========================================

    always @(posedge clk)
    begin
        int                    n;
        int                    space;
        logic [`FH_DATA_W-1:0] line;
        #1;
        csr_wr_en = 1'b0;
        mem_wr_en = 1'b0;
        if (run_en)
        begin
            grant_try = (rand_bits(2) != '0);
            ret_try   = (rand_bits(1) != '0);
            ret_pick  = 3'(rand_bits(3));
            // Long client stalls back the data up into the scoreboard
            if (hold_left > 0)
            begin
                hold_left--;
                rx_enable = 1'b0;
            end
            else if (rand_bits(4) == '0)
            begin
                hold_left = 20 + int'(rand_bits(5));
                rx_enable = 1'b0;
            end
            else
                rx_enable = (rand_bits(2) != '0);

            if (batch_left > 0)
            begin
                line                       = rand_bits(64);
                mem_wr_en                  = 1'b1;
                mem_wr_idx                 = 6'(fill_pos);
                mem_wr_data                = line;
                ring_model[6'(fill_pos)]   = line;
                fill_pos++;
                batch_left--;
                post_pending = (batch_left == 0);
            end
            else if (post_pending)
            begin
                // The new newest index makes the whole batch visible at once
                csr_wr_en    = 1'b1;
                csr_sel      = 1'b1;
                csr_wr_data  = 32'(fill_pos);
                posted       = fill_pos;
                post_pending = 1'b0;
            end
            else if (!base_moved && (posted >= 4 * RING_LINES) && (rx_count == posted))
            begin
                // Ring drained, so the base can move between two passes
                base_model  = 32'(rand_bits(32)) | 32'h0000_0100;
                csr_wr_en   = 1'b1;
                csr_sel     = 1'b0;
                csr_wr_data = base_model;
                base_moved  = 1'b1;
            end
            else if ((posted < TOTAL_LINES) && (rand_bits(1) != '0))
            begin
                // Only slots already taken by the client may be written again
                n     = 1 + int'(rand_bits(4));
                space = RING_LINES - 1 - (posted - rx_count);
                if (n > space)
                    n = space;
                if (n > TOTAL_LINES - posted)
                    n = TOTAL_LINES - posted;
                // Posting pauses at the end of the fourth pass until the base has moved
                if (!base_moved && (n > 4 * RING_LINES - posted))
                    n = 4 * RING_LINES - posted;
                batch_left = n;
            end
        end
    end

    // ========================================
    // Checks, sampled mid-cycle
    // ========================================

    always @(negedge clk)
    begin
        logic [`FH_ADDR_W-1:0]     exp_addr;
        logic [`FH_MDATA_W-1:0]    exp_tag;
        logic [`FH_RING_IDX_W-1:0] gap;
        if (resetb)
        begin
            // Nothing may be requested past the newest posted line
            assert (!rd_req || (req_count != posted_seen))
                else abort_run("rd_req raised with every posted line already requested");

            if (rd_grant)
            begin
                exp_addr = base_model + 32'(req_count % RING_LINES);
                assert (rd_addr == exp_addr)
                    else flag_mismatch("rd_addr", 64'(rd_addr), 64'(exp_addr));
                // The tag marks a read and names the slot handed out in request order
                exp_tag = {1'b1, 4'b0000, 3'(req_count % `FH_SB_ENTRIES)};
                assert ((rd_mdata & 8'h87) == exp_tag)
                    else flag_mismatch("rd_mdata", 64'(rd_mdata), 64'(exp_tag));
                req_count++;
            end
            if (rsp_valid)
                rsp_count++;
            assert (req_count - rsp_count <= `FH_SB_ENTRIES)
                else abort_run("More than eight reads outstanding");

            // A stalled line has to stay put until the client takes it
            if (held_prev)
            begin
                assert (rx_rdy)
                    else abort_run("rx_rdy dropped while the client was stalled");
                assert (rx_data == held_data)
                    else flag_mismatch("rx_data", rx_data, held_data);
            end

            // The output buffer holds at most two lines beyond what the client took
            gap = oldest_idx - 6'(rx_count);
            if (!rx_rdy)
            begin
                assert (gap == 6'd0)
                    else flag_mismatch("oldest_idx", 64'(oldest_idx), 64'(6'(rx_count)));
            end
            else
            begin
                assert ((gap == 6'd1) || (gap == 6'd2))
                    else flag_mismatch("oldest_idx", 64'(oldest_idx), 64'(6'(rx_count + 1)));
            end

            if (rx_rdy && rx_enable)
            begin
                assert (rx_data == ring_model[6'(rx_count)])
                    else flag_mismatch("rx_data", rx_data, ring_model[6'(rx_count)]);
                rx_count++;
            end

            held_prev = rx_rdy && !rx_enable;
            held_data = rx_data;
            if (csr_wr_en && csr_sel)
                posted_seen = posted;
        end
    end

    initial
    begin
        int cycles;
        resetb      = 1'b0;
        csr_wr_en   = 1'b0;
        csr_sel     = 1'b0;
        csr_wr_data = '0;
        rx_enable   = 1'b0;
        mem_wr_en   = 1'b0;
        mem_wr_idx  = '0;
        mem_wr_data = '0;
        base_model  = '0;
        grant_try   = 1'b0;
        ret_try     = 1'b0;
        ret_pick    = '0;

        repeat (4) @(posedge clk);
        #1;
        resetb = 1'b1;
        assert (rd_req == 1'b0)
            else flag_mismatch("rd_req", 64'(rd_req), 64'd0);
        assert (rx_rdy == 1'b0)
            else flag_mismatch("rx_rdy", 64'(rx_rdy), 64'd0);
        assert (oldest_idx == '0)
            else flag_mismatch("oldest_idx", 64'(oldest_idx), 64'd0);
        @(negedge clk);
        run_en = 1'b1;

        cycles = 0;
        while ((rx_count < TOTAL_LINES) && (cycles < MAX_CYCLES))
        begin
            @(posedge clk);
            cycles++;
        end
        if (rx_count < TOTAL_LINES)
            abort_run("Timed out waiting for the client to receive every line");
        else
        begin
            // With the ring drained the reader is idle and every line has left
            @(negedge clk);
            assert (base_moved)
                else abort_run("The ring base was never moved during the run");
            assert (oldest_idx == 6'(TOTAL_LINES))
                else flag_mismatch("oldest_idx", 64'(oldest_idx), 64'(6'(TOTAL_LINES)));
            assert (rx_rdy == 1'b0)
                else flag_mismatch("rx_rdy", 64'(rx_rdy), 64'd0);
            assert (rd_req == 1'b0)
                else flag_mismatch("rd_req", 64'(rd_req), 64'd0);
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/fifo_host_pkg.sv
hw/reorder_if.sv
hw/reorder_scoreboard.sv
hw/out_fifo2.sv
hw/ring_csr.sv
hw/ring_reader.sv
hw/fifo_from_host_top.sv
test/tb_clock.sv
test/tb_host_model.sv
test/tb_fifo_from_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the ring reader testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_fifo_from_host
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_fifo_from_host \
    -f all.f \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
    echo "Simulation passed, see $LOG_FILE"
    exit 0
fi

echo "Pass line missing from $LOG_FILE"
exit 1
